// File: common/flanger_consts.svh
`ifndef FLANGER_CONSTS_SVH
`define FLANGER_CONSTS_SVH

// Delay line geometry, depth must be a power of two
`define DELAY_DEPTH 64
`define ADDR_W 6

// Sweep limits in samples of delay
`define DELAY_MIN 4
`define DELAY_MAX 40

// Accepted samples per one-step change of the delay
`define SWEEP_STEP 8

`endif

// File: common/flanger_pkg.sv
package flanger_pkg;

  // One stereo frame, left channel in the upper half
  typedef struct packed {
    logic signed [15:0] left;
    logic signed [15:0] right;
  } sample_t;

  // Controller states
  typedef enum logic [2:0] {
    CLEAR,
    IDLE,
    READ,
    MIX,
    OUT_REQ,
    OUT_DONE,
    IN_ACK
  } ctrl_state_t;

endpackage

// File: flanger/delay_line_ram.sv
`timescale 1ns/1ps
`include "flanger_consts.svh"

module delay_line_ram (
  input  logic                 clk,
  input  logic                 n_rst,
  input  logic                 wr_en,
  input  logic [`ADDR_W-1:0]   wr_addr,
  input  logic [`ADDR_W-1:0]   rd_addr,
  input  flanger_pkg::sample_t wr_data,
  output flanger_pkg::sample_t rd_data
);

  flanger_pkg::sample_t mem [`DELAY_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data valid one cycle after rd_addr
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

  // Nonzero delay keeps the two ports apart
  a_no_collision: assert property (
    @(posedge clk) disable iff (!n_rst)
    wr_en |-> wr_addr != rd_addr
  );

endmodule

// File: flanger/flanger_ctrl.sv
`timescale 1ns/1ps

module flanger_ctrl (
  input  logic clk,
  input  logic n_rst,
  input  logic in_req,
  input  logic out_ack,
  input  logic wrapped,
  output logic in_ack,
  output logic out_req,
  output logic wr_en,
  output logic clear_step,
  output logic advance,
  output logic mix_load,
  output logic clearing
);

  flanger_pkg::ctrl_state_t state;
  flanger_pkg::ctrl_state_t next_state;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state <= flanger_pkg::CLEAR;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      flanger_pkg::CLEAR: begin
        // Last zero write goes to the top address
        if (wrapped) begin
          next_state = flanger_pkg::IDLE;
        end
      end
      flanger_pkg::IDLE: begin
        if (in_req) begin
          next_state = flanger_pkg::READ;
        end
      end
      flanger_pkg::READ: begin
        next_state = flanger_pkg::MIX;
      end
      flanger_pkg::MIX: begin
        next_state = flanger_pkg::OUT_REQ;
      end
      flanger_pkg::OUT_REQ: begin
        // Sink back-pressure holds us here
        if (out_ack) begin
          next_state = flanger_pkg::OUT_DONE;
        end
      end
      flanger_pkg::OUT_DONE: begin
        if (!out_ack) begin
          next_state = flanger_pkg::IN_ACK;
        end
      end
      flanger_pkg::IN_ACK: begin
        if (!in_req) begin
          next_state = flanger_pkg::IDLE;
        end
      end
      default: begin
        next_state = flanger_pkg::CLEAR;
      end
    endcase
  end

  assign clearing   = (state == flanger_pkg::CLEAR);
  assign clear_step = clearing;
  // Sample is stored in READ while the delayed one is fetched
  assign wr_en      = clearing || (state == flanger_pkg::READ);
  assign advance    = (state == flanger_pkg::MIX);
  assign mix_load   = (state == flanger_pkg::MIX);
  assign out_req    = (state == flanger_pkg::OUT_REQ);
  assign in_ack     = (state == flanger_pkg::IN_ACK);

  // Write pointer back at zero once the clear is done
  a_clear_wraps: assert property (
    @(posedge clk) disable iff (!n_rst)
    $fell(clearing) |-> !wrapped
  );

  // Input is only acknowledged once the output handshake is finished
  a_ack_after_out: assert property (
    @(posedge clk) disable iff (!n_rst)
    $rose(in_ack) |-> !out_req && !$past(out_req)
  );

endmodule

// File: flanger/flanger_mixer.sv
`timescale 1ns/1ps

module flanger_mixer (
  input  logic                 clk,
  input  logic                 n_rst,
  input  logic                 mix_load,
  input  logic                 flanger_en,
  input  flanger_pkg::sample_t dry,
  input  flanger_pkg::sample_t wet,
  output flanger_pkg::sample_t mix_out
);

  // 17-bit sum halved, cannot overflow
  function automatic logic signed [15:0] avg(
    input logic signed [15:0] a,
    input logic signed [15:0] b
  );
    logic signed [16:0] sum;
    sum = {a[15], a} + {b[15], b};
    return sum[16:1];
  endfunction

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      mix_out <= '0;
    end else if (mix_load) begin
      if (flanger_en) begin
        mix_out.left  <= avg(dry.left, wet.left);
        mix_out.right <= avg(dry.right, wet.right);
      end else begin
        mix_out <= dry;
      end
    end
  end

endmodule

// File: flanger/sweep_addr_gen.sv
`timescale 1ns/1ps
`include "flanger_consts.svh"

module sweep_addr_gen (
  input  logic               clk,
  input  logic               n_rst,
  input  logic               clear_step,
  input  logic               advance,
  output logic               wrapped,
  output logic [`ADDR_W-1:0] wr_addr,
  output logic [`ADDR_W-1:0] rd_addr
);

  localparam int STEP_W = $clog2(`SWEEP_STEP);

  logic [`ADDR_W-1:0] wr_ptr;
  logic [`ADDR_W-1:0] delay;
  logic [STEP_W-1:0]  step_cnt;
  logic               dir_up;

  assign wrapped = (wr_ptr == `ADDR_W'(`DELAY_DEPTH - 1));
  assign wr_addr = wr_ptr;
  // Wraps modulo the depth
  assign rd_addr = wr_ptr - delay;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      wr_ptr <= '0;
    end else if (clear_step || advance) begin
      if (wrapped) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // Triangle sweep, one step every SWEEP_STEP samples
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      step_cnt <= '0;
      delay    <= `ADDR_W'(`DELAY_MIN);
      dir_up   <= 1'b1;
    end else if (advance) begin
      if (step_cnt == STEP_W'(`SWEEP_STEP - 1)) begin
        step_cnt <= '0;
        if (dir_up) begin
          delay <= delay + 1'b1;
          if (delay + 1'b1 == `ADDR_W'(`DELAY_MAX)) begin
            dir_up <= 1'b0;
          end
        end else begin
          delay <= delay - 1'b1;
          if (delay - 1'b1 == `ADDR_W'(`DELAY_MIN)) begin
            dir_up <= 1'b1;
          end
        end
      end else begin
        step_cnt <= step_cnt + 1'b1;
      end
    end
  end

  a_delay_range: assert property (
    @(posedge clk) disable iff (!n_rst)
    delay >= `ADDR_W'(`DELAY_MIN) && delay <= `ADDR_W'(`DELAY_MAX)
  );

endmodule

// File: flanger_top.f
+incdir+common
common/flanger_pkg.sv
flanger/flanger_ctrl.sv
flanger/sweep_addr_gen.sv
flanger/delay_line_ram.sv
flanger/flanger_mixer.sv
src/flanger_top.sv
test/flanger_checker.sv
test/tb_flanger_top.sv

// File: src/flanger_top.sv
`timescale 1ns/1ps
`include "flanger_consts.svh"

module flanger_top (
  input  logic                 clk,
  input  logic                 n_rst,
  input  logic                 flanger_en,
  input  logic                 in_req,
  input  logic                 out_ack,
  input  flanger_pkg::sample_t in_data,
  output logic                 in_ack,
  output logic                 out_req,
  output flanger_pkg::sample_t out_data
);

  logic                 wr_en;
  logic                 clear_step;
  logic                 advance;
  logic                 mix_load;
  logic                 clearing;
  logic                 wrapped;
  logic [`ADDR_W-1:0]   wr_addr;
  logic [`ADDR_W-1:0]   rd_addr;
  flanger_pkg::sample_t wr_data;
  flanger_pkg::sample_t rd_data;

  // Zeros go into the delay line while it is being cleared
  assign wr_data = clearing ? '0 : in_data;

  flanger_ctrl u_ctrl (
    .clk        (clk),
    .n_rst      (n_rst),
    .in_req     (in_req),
    .out_ack    (out_ack),
    .wrapped    (wrapped),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .wr_en      (wr_en),
    .clear_step (clear_step),
    .advance    (advance),
    .mix_load   (mix_load),
    .clearing   (clearing)
  );

  sweep_addr_gen u_addr (
    .clk        (clk),
    .n_rst      (n_rst),
    .clear_step (clear_step),
    .advance    (advance),
    .wrapped    (wrapped),
    .wr_addr    (wr_addr),
    .rd_addr    (rd_addr)
  );

  delay_line_ram u_ram (
    .clk     (clk),
    .n_rst   (n_rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  flanger_mixer u_mixer (
    .clk        (clk),
    .n_rst      (n_rst),
    .mix_load   (mix_load),
    .flanger_en (flanger_en),
    .dry        (in_data),
    .wet        (rd_data),
    .mix_out    (out_data)
  );

endmodule

// File: test/flanger_checker.sv
`timescale 1ns/1ps
`include "flanger_consts.svh"

module flanger_checker (
  input  logic                 clk,
  input  logic                 n_rst,
  input  logic                 flanger_en,
  input  logic                 in_req,
  input  logic                 in_ack,
  input  logic                 out_req,
  input  logic                 out_ack,
  input  flanger_pkg::sample_t in_data,
  input  flanger_pkg::sample_t out_data,
  output int                   err_cnt,
  output int                   out_cnt,
  output bit                   sweep_turned
);

  flanger_pkg::sample_t hist[$];
  flanger_pkg::sample_t expected;
  int n;
  int d;
  int step;
  bit up;
  bit busy;
  bit out_seen;
  bit prev_out_req;
  bit prev_out_ack;
  bit hit_max;
  int edges;
  int clear_edges;

  // Average of two channel values, or the dry value in bypass
  function automatic logic signed [15:0] model_channel(
    input logic signed [15:0] dry,
    input logic signed [15:0] wet,
    input logic               en
  );
    int s;
    s = int'(dry) + int'(wet);
    if (en) begin
      return 16'(s >>> 1);
    end
    return dry;
  endfunction

  initial begin
    err_cnt = 0;
    out_cnt = 0;
    sweep_turned = 0;
    n = 0;
    d = `DELAY_MIN;
    step = 0;
    up = 1;
    busy = 0;
    out_seen = 0;
    prev_out_req = 0;
    prev_out_ack = 0;
    hit_max = 0;
    edges = 0;
    clear_edges = 0;
  end

  task automatic accept_sample();
    flanger_pkg::sample_t wet;
    wet = (n >= d) ? hist[n - d] : '0;
    expected.left  = model_channel(in_data.left, wet.left, flanger_en);
    expected.right = model_channel(in_data.right, wet.right, flanger_en);
    hist.push_back(in_data);
    n++;
    step++;
    // Triangle sweep of the model delay
    if (step == `SWEEP_STEP) begin
      step = 0;
      if (up) begin
        d++;
        if (d == `DELAY_MAX) begin
          up = 0;
          hit_max = 1;
        end
      end else begin
        d--;
        if (d == `DELAY_MIN) begin
          up = 1;
          if (hit_max) begin
            sweep_turned = 1;
          end
        end
      end
    end
  endtask

  always @(posedge clk) begin
    if (n_rst) begin
      if (clear_edges < `DELAY_DEPTH) begin
        if (in_ack || out_req) begin
          $display("Handshake active during delay-line clear at edge %0d", clear_edges);
          err_cnt++;
        end
        clear_edges++;
      end else begin
        if (in_ack && out_req) begin
          $display("in_ack and out_req high together at sample %0d", n);
          err_cnt++;
        end
        if (!busy) begin
          if (out_req) begin
            $display("out_req raised with no accepted input");
            err_cnt++;
          end
          if (in_req && !in_ack) begin
            accept_sample();
            busy = 1;
            out_seen = 0;
            edges = 0;
          end
        end else begin
          edges++;
          if (!out_seen) begin
            if (out_req) begin
              if (edges != 3) begin
                $display("out_req rose %0d edges after in_req instead of 3", edges);
                err_cnt++;
              end
              if (out_data !== expected) begin
                $display("Fail out_data sample %0d: got %h, expected %h",
                         n - 1, out_data, expected);
                err_cnt++;
              end
              out_cnt++;
              out_seen = 1;
            end else if (in_ack) begin
              $display("in_ack raised before the output of sample %0d", n - 1);
              err_cnt++;
            end
          end else if (out_req && !prev_out_req) begin
            $display("Second output for sample %0d", n - 1);
            err_cnt++;
          end
          if (out_seen && prev_out_req && !out_req && !prev_out_ack) begin
            $display("out_req dropped before out_ack for sample %0d", n - 1);
            err_cnt++;
          end
          if (in_ack && !in_req) begin
            busy = 0;
          end
        end
      end
      prev_out_req = out_req;
      prev_out_ack = out_ack;
    end
  end

endmodule

// File: test/tb_flanger_top.sv
`timescale 1ns/1ps
`include "flanger_consts.svh"

module tb_flanger_top;

  localparam int TOTAL_SAMPLES = 851;
  // Worst case: source gap, sink stall and handshake overhead
  localparam int CYCLES_PER_SAMPLE = 60;
  localparam int WATCHDOG_NS = (TOTAL_SAMPLES * CYCLES_PER_SAMPLE + `DELAY_DEPTH + 10) * 20;

  logic                 clk;
  logic                 n_rst;
  logic                 flanger_en;
  logic                 in_req;
  logic                 out_ack;
  flanger_pkg::sample_t in_data;
  logic                 in_ack;
  logic                 out_req;
  flanger_pkg::sample_t out_data;

  int err_cnt;
  int out_cnt;
  bit sweep_turned;
  int tb_err;
  int sent;
  int sink_max;

  flanger_top i_flanger_top (
    .clk        (clk),
    .n_rst      (n_rst),
    .flanger_en (flanger_en),
    .in_req     (in_req),
    .out_ack    (out_ack),
    .in_data    (in_data),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_data   (out_data)
  );

  flanger_checker i_checker (
    .clk          (clk),
    .n_rst        (n_rst),
    .flanger_en   (flanger_en),
    .in_req       (in_req),
    .in_ack       (in_ack),
    .out_req      (out_req),
    .out_ack      (out_ack),
    .in_data      (in_data),
    .out_data     (out_data),
    .err_cnt      (err_cnt),
    .out_cnt      (out_cnt),
    .sweep_turned (sweep_turned)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d outputs", WATCHDOG_NS, out_cnt);
    $display("Done: errors found");
    $finish;
  end

  // Answers each out_req after a random number of cycles
  task automatic sink_loop();
    int wait_cycles;
    forever begin
      @(negedge clk);
      if (out_req && !out_ack) begin
        wait_cycles = $urandom_range(sink_max, 0);
        repeat (wait_cycles) @(negedge clk);
        out_ack = 1'b1;
        do @(negedge clk); while (out_req);
        out_ack = 1'b0;
      end
    end
  endtask

  task automatic send_sample(input logic en, input int gap_max);
    int gap;
    gap = $urandom_range(gap_max, 0);
    repeat (gap) @(negedge clk);
    flanger_en = en;
    in_data = $urandom;
    in_req = 1'b1;
    do @(negedge clk); while (!in_ack);
    in_req = 1'b0;
    do @(negedge clk); while (in_ack);
    sent++;
  endtask

  // en_mode 0 is bypass, 1 is flanger on, 2 picks at random per sample
  task automatic run_test(input string name, input int count, input int en_mode,
                          input int gap_max, input int stall_max);
    int errs_before;
    logic en;
    errs_before = tb_err + err_cnt;
    sink_max = stall_max;
    for (int i = 0; i < count; i++) begin
      en = (en_mode == 2) ? logic'($urandom_range(1, 0)) : logic'(en_mode);
      send_sample(en, gap_max);
    end
    $display("Test %s: %0d samples, %0d errors", name, count,
             tb_err + err_cnt - errs_before);
  endtask

  initial begin
    void'($urandom(32'h4c89));
    n_rst = 1'b0;
    flanger_en = 1'b0;
    in_req = 1'b0;
    out_ack = 1'b0;
    in_data = '0;
    tb_err = 0;
    sent = 0;
    sink_max = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    n_rst = 1'b1;
    fork
      sink_loop();
    join_none

    run_test("clear_wait", 1, 1, 0, 0);
    run_test("wet_start", 60, 1, 3, 4);
    run_test("bypass", 50, 0, 3, 4);
    run_test("sweep", 640, 2, 2, 3);
    if (!sweep_turned) begin
      $display("Sweep did not reach both delay limits");
      tb_err++;
    end
    run_test("sink_stall", 100, 2, 8, 40);

    if (out_cnt != sent) begin
      $display("Output count %0d does not match %0d samples sent", out_cnt, sent);
      tb_err++;
    end
    $display("Tests: 5, samples: %0d, outputs: %0d, errors: %0d",
             sent, out_cnt, tb_err + err_cnt);
    if (tb_err + err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
